// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench

VERILATOR ?= verilator
TOP       ?= async_fifo_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
	  echo "simulation reported failure"; \
	  exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
	  echo "simulation ended without a result line"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// ==== logic/async_fifo.sv ====
`timescale 1ns/10ps

module async_fifo import fifo_pkg::*; #(
  parameter int data_width   = DEF_DATA_WIDTH,
  parameter int fifo_depth   = DEF_FIFO_DEPTH,  // power of two
  parameter int afull_level  = fifo_depth - 1,
  parameter int aempty_level = 1
) (
  // write domain
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [data_width-1:0] wr_data,
  output logic                  full,
  output logic                  afull,
  // read domain
  input  logic                  rd_clk,
  input  logic                  rd_en,
  output logic [data_width-1:0] rd_data,
  output logic                  empty,
  output logic                  aempty,
  // clears both sides
  input  logic                  wr_rst_n
);

  localparam int addr_width = $clog2(fifo_depth);

  ptr_t wr_gray;  // wr_clk flop, synced in rd_ctrl
  ptr_t rd_gray;  // rd_clk flop, synced in wr_ctrl

  fifo_mem_if #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) mem_if ();

  fifo_wr_ctrl #(
    .data_width  (data_width),
    .fifo_depth  (fifo_depth),
    .afull_level (afull_level)
  ) u_wr_ctrl (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_gray  (rd_gray),
    .wr_gray  (wr_gray),
    .full     (full),
    .afull    (afull),
    .mem      (mem_if.writer)
  );

  fifo_rd_ctrl #(
    .fifo_depth   (fifo_depth),
    .aempty_level (aempty_level)
  ) u_rd_ctrl (
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .rd_en    (rd_en),
    .wr_gray  (wr_gray),
    .rd_gray  (rd_gray),
    .empty    (empty),
    .aempty   (aempty),
    .mem      (mem_if.reader)
  );

  fifo_mem #(
    .data_width (data_width),
    .fifo_depth (fifo_depth)
  ) u_mem (
    .wr_clk   (wr_clk),
    .rd_clk   (rd_clk),
    .wr_rst_n (wr_rst_n),
    .port     (mem_if.mem)
  );

  assign rd_data = mem_if.rd_data;

endmodule

// ==== logic/fifo_mem.sv ====
`timescale 1ns/10ps

module fifo_mem import fifo_pkg::*; #(
  parameter int data_width = DEF_DATA_WIDTH,
  parameter int fifo_depth = DEF_FIFO_DEPTH
) (
  input  logic    wr_clk,
  input  logic    rd_clk,
  input  logic    wr_rst_n,
  fifo_mem_if.mem port
);

  logic [data_width-1:0] ram [fifo_depth];

  // write side, no reset on the array
  always_ff @(posedge wr_clk) begin
    if (port.wr_en) begin
      ram[port.wr_addr] <= port.wr_data;
    end
  end

  // registered read port
  // word shows up one rd_clk after the accepted read
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      port.rd_data <= '0;
    end else if (port.rd_en) begin
      port.rd_data <= ram[port.rd_addr];
    end
  end

endmodule

// ==== logic/fifo_mem_if.sv ====
`timescale 1ns/10ps

interface fifo_mem_if import fifo_pkg::*; #(
  parameter int data_width = DEF_DATA_WIDTH,
  parameter int addr_width = $clog2(DEF_FIFO_DEPTH)
);

  // write port, wr_clk domain
  logic                  wr_en;
  logic [addr_width-1:0] wr_addr;
  logic [data_width-1:0] wr_data;

  // read port, rd_clk domain
  logic                  rd_en;
  logic [addr_width-1:0] rd_addr;
  logic [data_width-1:0] rd_data;  // registered in the memory

  modport writer (output wr_en, wr_addr, wr_data);

  modport reader (output rd_en, rd_addr);

  modport mem (
    input  wr_en, wr_addr, wr_data,
    input  rd_en, rd_addr,
    output rd_data
  );

endinterface

// ==== logic/fifo_pkg.sv ====
package fifo_pkg;

  // widest pointer supported, narrower fifos use the low bits
  localparam int MAX_PTR_W = 16;

  localparam int DEF_DATA_WIDTH = 8;
  localparam int DEF_FIFO_DEPTH = 16;  // power of two

  typedef logic [MAX_PTR_W-1:0] ptr_t;

  // binary to reflected gray
  function automatic ptr_t bin_to_gray(ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // gray back to binary, prefix xor from the msb down
  function automatic ptr_t gray_to_bin(ptr_t gray);
    ptr_t bin;
    bin[MAX_PTR_W-1] = gray[MAX_PTR_W-1];
    for (int i = MAX_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// ==== logic/fifo_rd_ctrl.sv ====
`timescale 1ns/10ps

module fifo_rd_ctrl import fifo_pkg::*; #(
  parameter int fifo_depth   = DEF_FIFO_DEPTH,
  parameter int aempty_level = 1
) (
  input  logic       rd_clk,
  input  logic       wr_rst_n,
  input  logic       rd_en,
  input  ptr_t       wr_gray,
  output ptr_t       rd_gray,
  output logic       empty,
  output logic       aempty,
  fifo_mem_if.reader mem
);

  localparam int addr_width = $clog2(fifo_depth);
  localparam int ptr_w      = addr_width + 1;

  logic [ptr_w-1:0] rd_bin;
  logic [ptr_w-1:0] rd_bin_nxt;
  ptr_t             rd_gray_nxt;
  logic [ptr_w-1:0] wr_gray_s1;
  logic [ptr_w-1:0] wr_gray_s2;
  ptr_t             wr_bin_sync;
  logic [ptr_w-1:0] used_nxt;
  logic             rd_acc;
  logic             empty_nxt;

  assign rd_acc      = rd_en && !empty;  // dropped while empty
  assign rd_bin_nxt  = rd_bin + ptr_w'(rd_acc);
  assign rd_gray_nxt = bin_to_gray(ptr_t'(rd_bin_nxt));

  // caught up with the synced write pointer
  assign empty_nxt = rd_gray_nxt[ptr_w-1:0] == wr_gray_s2;

  // synced write pointer lags, so the count is never high
  assign wr_bin_sync = gray_to_bin(ptr_t'(wr_gray_s2));
  assign used_nxt    = wr_bin_sync[ptr_w-1:0] - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_bin  <= '0;
      rd_gray <= '0;
      empty   <= 1'b1;
      aempty  <= 1'b1;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_gray_nxt;
      empty   <= empty_nxt;
      aempty  <= used_nxt <= aempty_level;
    end
  end

  // write gray pointer into rd_clk
  always_ff @(posedge rd_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray[ptr_w-1:0];
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  assign mem.rd_en   = rd_acc;
  assign mem.rd_addr = rd_bin[addr_width-1:0];  // current pointer, data next edge

endmodule

// ==== logic/fifo_wr_ctrl.sv ====
`timescale 1ns/10ps

module fifo_wr_ctrl import fifo_pkg::*; #(
  parameter int data_width  = DEF_DATA_WIDTH,
  parameter int fifo_depth  = DEF_FIFO_DEPTH,
  parameter int afull_level = fifo_depth - 1
) (
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [data_width-1:0] wr_data,
  input  ptr_t                  rd_gray,
  output ptr_t                  wr_gray,
  output logic                  full,
  output logic                  afull,
  fifo_mem_if.writer            mem
);

  localparam int addr_width = $clog2(fifo_depth);
  localparam int ptr_w      = addr_width + 1;  // extra wrap bit

  logic [ptr_w-1:0] wr_bin;
  logic [ptr_w-1:0] wr_bin_nxt;
  ptr_t             wr_gray_nxt;
  logic [ptr_w-1:0] rd_gray_s1;
  logic [ptr_w-1:0] rd_gray_s2;
  ptr_t             rd_bin_sync;
  logic [ptr_w-1:0] used_nxt;
  logic             wr_acc;
  logic             full_nxt;

  assign wr_acc      = wr_en && !full;  // dropped while full
  assign wr_bin_nxt  = wr_bin + ptr_w'(wr_acc);
  assign wr_gray_nxt = bin_to_gray(ptr_t'(wr_bin_nxt));

  // full when the next pointer is one lap ahead of the read pointer
  assign full_nxt = wr_gray_nxt[ptr_w-1:0] ==
                    {~rd_gray_s2[ptr_w-1:ptr_w-2], rd_gray_s2[ptr_w-3:0]};

  // used count seen from the write side, never low
  assign rd_bin_sync = gray_to_bin(ptr_t'(rd_gray_s2));
  assign used_nxt    = wr_bin_nxt - rd_bin_sync[ptr_w-1:0];

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin  <= '0;
      wr_gray <= '0;
      full    <= 1'b0;
      afull   <= 1'b0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_gray_nxt;  // crosses to rd_clk from a flop
      full    <= full_nxt;
      afull   <= used_nxt >= afull_level;
    end
  end

  // two stage sync of the read gray pointer
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray[ptr_w-1:0];
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  assign mem.wr_en   = wr_acc;
  assign mem.wr_addr = wr_bin[addr_width-1:0];
  assign mem.wr_data = wr_data;

endmodule

// ==== tests/async_fifo_assert.sv ====
`timescale 1ns/10ps

module async_fifo_assert import fifo_pkg::*; (
  input logic wr_clk,
  input logic rd_clk,
  input logic wr_rst_n,
  input logic full,
  input logic afull,
  input logic empty,
  input logic aempty,
  input ptr_t wr_gray,
  input ptr_t rd_gray
);

  int fail_count = 0;  // read by the testbench

  // flags from both domains, sampled on the faster clock
  full_empty_excl: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    !(full && empty)) else begin
    fail_count++;
    $error("full and empty set together");
  end

  wr_gray_step: assert property (@(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1) else begin
    fail_count++;
    $error("write gray pointer changed more than one bit");
  end

  rd_gray_step: assert property (@(posedge rd_clk) disable iff (!wr_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1) else begin
    fail_count++;
    $error("read gray pointer changed more than one bit");
  end

  wr_flags_rst: assert property (@(posedge wr_clk) !wr_rst_n |-> (!full && !afull)) else begin
    fail_count++;
    $error("write flags left their reset values during reset");
  end

  rd_flags_rst: assert property (@(posedge rd_clk) !wr_rst_n |-> (empty && aempty)) else begin
    fail_count++;
    $error("read flags left their reset values during reset");
  end

endmodule

bind async_fifo async_fifo_assert u_assert (
  .wr_clk   (wr_clk),
  .rd_clk   (rd_clk),
  .wr_rst_n (wr_rst_n),
  .full     (full),
  .afull    (afull),
  .empty    (empty),
  .aempty   (aempty),
  .wr_gray  (wr_gray),
  .rd_gray  (rd_gray)
);

// ==== tests/async_fifo_tb.sv ====
`timescale 1ns/10ps

module async_fifo_tb;
  import fifo_pkg::*;

  localparam int data_width   = 8;
  localparam int fifo_depth   = 16;
  localparam int afull_level  = fifo_depth - 1;
  localparam int aempty_level = 1;
  localparam int rd_period    = 4;
  localparam int rec_fields   = 9;
  localparam int max_recs     = 64;
  localparam logic [31:0] seed = 32'hf914f42d;

  typedef logic [3:0] flags_t;  // full, empty, afull, aempty

  logic wr_clk, rd_clk, wr_rst_n;
  logic wr_en, rd_en;
  logic [data_width-1:0] wr_data, rd_data;
  logic full, afull, empty, aempty;

  logic [15:0] stim [0:max_recs*rec_fields-1];
  logic [data_width-1:0] sb_q [$];  // words written, not yet read
  logic [data_width-1:0] rd_expect;
  logic [31:0] wr_lfsr, rd_lfsr;
  logic rd_pending, fill_check;
  int err_count, check_count, wr_taken, rd_taken, watch_limit;

  async_fifo #(
    .data_width   (data_width),
    .fifo_depth   (fifo_depth),
    .afull_level  (afull_level),
    .aempty_level (aempty_level)
  ) dut (
    .wr_clk (wr_clk), .wr_en (wr_en), .wr_data (wr_data), .full (full), .afull (afull),
    .rd_clk (rd_clk), .rd_en (rd_en), .rd_data (rd_data), .empty (empty), .aempty (aempty),
    .wr_rst_n (wr_rst_n)
  );

  initial begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;
  end

  initial begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], st[0]};
      st  = lfsr_next(st);
    end
  endtask

  task automatic compare_data(input logic [data_width-1:0] got, input logic [data_width-1:0] exp,
                              input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic compare_flags(input flags_t got, input flags_t exp, input flags_t care,
                               input string what);
    check_count++;
    if ((got & care) !== (exp & care)) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s, full/empty/afull/aempty got %b expected %b",
               $time, what, got, exp);
    end
  endtask

  task automatic drive_writes(input int count, input int gap);
    logic [31:0] v;
    int idle;
    for (int i = 0; i < count; i++) begin
      @(posedge wr_clk);
      #1;
      take_bits(wr_lfsr, data_width, v);
      wr_en   = 1'b1;
      wr_data = v[data_width-1:0];
      take_bits(wr_lfsr, 3, v);
      idle = int'(v[2:0]) % (gap + 1);
      repeat (idle) begin
        @(posedge wr_clk);
        #1;
        wr_en = 1'b0;
      end
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic drive_reads(input int count, input int gap);
    logic [31:0] v;
    int idle;
    for (int i = 0; i < count; i++) begin
      @(posedge rd_clk);
      #1;
      rd_en = 1'b1;
      take_bits(rd_lfsr, 3, v);
      idle = int'(v[2:0]) % (gap + 1);
      repeat (idle) begin
        @(posedge rd_clk);
        #1;
        rd_en = 1'b0;
      end
    end
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
  endtask

  // strobe and flag are stable at the falling edge, the write lands at the next rise
  always @(negedge wr_clk) begin
    if (fill_check) begin  // no reads in flight, so the count is exact
      compare_flags({full, 1'b0, afull, 1'b0},
                    {sb_q.size() >= fifo_depth, 1'b0, sb_q.size() >= afull_level, 1'b0},
                    4'b1010, "write flags during fill");
    end
    if (wr_en && !full) begin
      sb_q.push_back(wr_data);
      wr_taken++;
    end
  end

  always @(negedge rd_clk) begin
    if (rd_pending) begin
      compare_data(rd_data, rd_expect, "read data");  // one rd_clk after acceptance
    end
    rd_pending = rd_en && !empty;
    if (rd_pending) begin
      rd_taken++;
      if (sb_q.size() == 0) begin
        err_count++;
        $display("error at %0t: a read was accepted with no word written", $time);
        rd_expect = '0;
      end else begin
        rd_expect = sb_q.pop_front();
      end
    end
  end

  task automatic run_test(input int rec);
    int base, id, n_wr, n_rd, err0;
    flags_t exp;
    base = rec * rec_fields;
    id   = int'(stim[base]);
    n_wr = int'(stim[base+1]);
    n_rd = int'(stim[base+2]);
    exp  = {stim[base+5][0], stim[base+6][0], stim[base+7][0], stim[base+8][0]};
    err0 = err_count;
    wr_taken   = 0;
    rd_taken   = 0;
    fill_check = (n_rd == 0);
    fork
      drive_writes(n_wr, int'(stim[base+3]));
      drive_reads(n_rd, int'(stim[base+4]));
    join
    repeat (12) @(posedge rd_clk);
    repeat (4) @(posedge wr_clk);
    @(negedge rd_clk);
    fill_check = 1'b0;
    compare_flags({full, empty, afull, aempty}, exp, 4'hf, $sformatf("end flags, test %0d", id));
    $display("test %0d: %0d of %0d writes, %0d of %0d reads accepted, %s", id,
             wr_taken, n_wr, rd_taken, n_rd, (err_count == err0) ? "ok" : "failed");
  endtask

  initial begin
    int n_tests;
    int total_ops;
    wr_en      = 1'b0;
    wr_data    = '0;
    rd_en      = 1'b0;
    wr_rst_n   = 1'b1;
    wr_lfsr    = seed;
    rd_lfsr    = seed;
    rd_pending = 1'b0;
    fill_check = 1'b0;
    err_count  = 0;
    check_count = 0;
    for (int i = 0; i < max_recs * rec_fields; i++) begin
      stim[i] = '0;
    end
    $readmemh("tests/fifo_stimulus.txt", stim);
    n_tests   = 0;
    total_ops = 0;
    while (n_tests < max_recs && stim[n_tests*rec_fields] != 0) begin
      total_ops += int'(stim[n_tests*rec_fields+1]) + int'(stim[n_tests*rec_fields+2]);
      n_tests++;
    end
    watch_limit = (total_ops * 20 + n_tests * 60 + 200) * rd_period;
    #1 wr_rst_n = 1'b0;
    repeat (10) @(posedge rd_clk);
    #1 wr_rst_n = 1'b1;
    compare_data(rd_data, '0, "rd_data after reset");
    repeat (4) @(posedge wr_clk);
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    err_count += dut.u_assert.fail_count;
    $display("tests %0d, checks %0d, errors %0d", n_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (watch_limit > 0);
    #(watch_limit);
    $display("timeout: the tests did not finish within %0d ns", watch_limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tests/fifo_stimulus.txt ====
// id wr_count rd_count wr_gap rd_gap full empty afull aempty, all hex
// gaps are the longest idle run between strobes, in cycles of the own clock
// flags are the values expected once both domains have settled

// reset state
01 00 00 0 0 0 1 0 1
// fill past depth, four writes dropped while full
02 14 00 0 0 1 0 1 0
// drain past empty, four reads dropped
03 00 14 0 0 0 1 0 1
// afull without full
04 0f 00 2 0 0 0 1 0
// last slot, then two dropped writes
05 03 00 0 0 1 0 1 0
// leave one word, aempty only
06 00 0f 0 1 0 0 0 1
07 00 03 0 0 0 1 0 1
08 01 00 0 0 0 0 0 1

// concurrent traffic, writes outlast reads so it ends full
09 50 14 0 3 1 0 1 0
// concurrent traffic, reads outlast writes so it ends empty
0a 14 64 1 0 0 1 0 1
// half full, no flags
0b 08 00 5 0 0 0 0 0
0c 04 30 0 2 0 1 0 1

// ==== verilog.f ====
logic/fifo_pkg.sv
logic/fifo_mem_if.sv
logic/fifo_mem.sv
logic/fifo_wr_ctrl.sv
logic/fifo_rd_ctrl.sv
logic/async_fifo.sv
tests/async_fifo_assert.sv
tests/async_fifo_tb.sv
